// ==== logic/arp_settings.svh ====
`ifndef ARP_SETTINGS_SVH
`define ARP_SETTINGS_SVH

// Switch geometry
`define ARP_NUM_PORTS       20
`define ARP_PORT_FIELD_W    24

// Frame size in bytes on the shared bus
`define ARP_FRAME_LEN       64

// Ethernet and ARP header constants
`define ARP_BROADCAST_BYTE  8'hff
`define ARP_ETHERTYPE       16'h0806
`define ARP_HTYPE           16'h0001
`define ARP_PTYPE           16'h0800
`define ARP_HLEN            8'd6
`define ARP_PLEN            8'd4
`define ARP_OPER_REQUEST    16'h0001

// Address widths
`define ARP_IP_W            32
`define ARP_MAC_W           48

`endif

// ==== logic/arp_pkg.sv ====
`include "arp_settings.svh"

package arp_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Addresses

	typedef logic [`ARP_IP_W-1:0] ip_addr_t;
	typedef logic [`ARP_MAC_W-1:0] mac_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// Port selection

	// Request port field is one-hot but wider than the port count
	typedef logic [`ARP_PORT_FIELD_W-1:0] port_field_t;
	typedef logic [$clog2(`ARP_NUM_PORTS)-1:0] port_index_t;
	typedef logic [`ARP_NUM_PORTS-1:0] port_mask_t;

	////////////////////////////////////////////////////////////////////////////
	// Frame bus

	typedef logic [$clog2(`ARP_FRAME_LEN)-1:0] byte_index_t;
	typedef logic [7:0] tx_byte_t;

	// Own addresses, one entry per port
	typedef ip_addr_t [`ARP_NUM_PORTS-1:0] port_ip_table_t;
	typedef mac_addr_t [`ARP_NUM_PORTS-1:0] port_mac_table_t;

endpackage

// ==== logic/arp_request_capture.sv ====
`timescale 1ns/1ps
`include "arp_settings.svh"

module arp_request_capture (
	input  logic                  clk,
	input  logic                  idle,
	input  arp_pkg::port_field_t  lut_port,
	input  arp_pkg::ip_addr_t     lut_ip,
	input  logic                  lut_en,
	input  arp_pkg::port_field_t  fade_port,
	input  arp_pkg::ip_addr_t     fade_ip,
	input  logic                  fade_en,
	output logic                  req_pending,
	output logic                  port_valid,
	output arp_pkg::port_index_t  port_index,
	output arp_pkg::ip_addr_t     target_ip
);

	arp_pkg::port_field_t field_q;
	logic one_hot;
	logic in_range;

	assign req_pending = lut_en | fade_en;

	// Lookup miss wins over expiry
	always_ff @(posedge clk) begin
		if (idle) begin
			if (lut_en) begin
				field_q   <= lut_port;
				target_ip <= lut_ip;
			end else if (fade_en) begin
				field_q   <= fade_port;
				target_ip <= fade_ip;
			end else begin
				field_q   <= '0;
				target_ip <= '0;
			end
		end
	end

	// Exactly one bit, and only on an existing port
	assign one_hot  = (field_q != '0) && ((field_q & (field_q - arp_pkg::port_field_t'(1))) == '0);
	assign in_range = ~|field_q[`ARP_PORT_FIELD_W-1:`ARP_NUM_PORTS];
	assign port_valid = one_hot && in_range;

	always_comb begin
		port_index = '0;
		for (int i = 0; i < `ARP_NUM_PORTS; i++) begin
			if (field_q[i]) begin
				port_index = arp_pkg::port_index_t'(i);
			end
		end
	end

endmodule

// ==== logic/arp_request_sequencer.sv ====
`timescale 1ns/1ps
`include "arp_settings.svh"

module arp_request_sequencer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  req_pending,
	input  logic                  port_valid,
	input  arp_pkg::port_index_t  port_index,
	input  arp_pkg::port_mask_t   req_ack,
	output logic                  idle,
	output logic                  sending,
	output arp_pkg::byte_index_t  byte_index,
	output arp_pkg::port_mask_t   req_ready
);

	typedef enum logic [1:0] {
		IDLE,
		HOLD,
		SEND
	} state_t;

	localparam arp_pkg::byte_index_t LAST_BYTE = arp_pkg::byte_index_t'(`ARP_FRAME_LEN - 1);

	state_t state;
	logic ack_hit;
	logic last_byte;
	arp_pkg::port_mask_t port_bit;

	assign port_bit = arp_pkg::port_mask_t'(1) << port_index;

	// Only the captured port's ack counts
	assign ack_hit   = port_valid && ((req_ack & port_bit) != '0);
	assign last_byte = (byte_index == LAST_BYTE);

	////////////////////////////////////////////////////////////////////////////
	// State machine

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (req_pending) begin
						state <= HOLD;
					end
				end
				HOLD: begin
					if (!port_valid) begin
						state <= IDLE;
					end else if (ack_hit) begin
						state <= SEND;
					end
				end
				SEND: begin
					if (last_byte) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Byte counter

	always_ff @(posedge clk) begin
		if (rst || state != SEND) begin
			byte_index <= '0;
		end else begin
			byte_index <= byte_index + 1'b1;
		end
	end

	assign idle    = (state == IDLE);
	assign sending = (state == SEND);

	// Ready on the captured port for as long as we wait
	assign req_ready = (state == HOLD && port_valid) ? port_bit : '0;

endmodule

// ==== logic/arp_frame_builder.sv ====
`timescale 1ns/1ps
`include "arp_settings.svh"

module arp_frame_builder (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      sending,
	input  arp_pkg::byte_index_t      byte_index,
	input  arp_pkg::port_index_t      port_index,
	input  arp_pkg::ip_addr_t         target_ip,
	input  arp_pkg::port_ip_table_t   local_ip,
	input  arp_pkg::port_mac_table_t  local_mac,
	output arp_pkg::tx_byte_t         tx_data,
	output arp_pkg::port_mask_t       tx_en
);

	// Ethertype through opcode fill frame bytes 12 to 21
	localparam logic [79:0] FIXED_HDR = {
		`ARP_ETHERTYPE,
		`ARP_HTYPE,
		`ARP_PTYPE,
		`ARP_HLEN,
		`ARP_PLEN,
		`ARP_OPER_REQUEST
	};

	arp_pkg::mac_addr_t own_mac;
	arp_pkg::ip_addr_t own_ip;
	arp_pkg::tx_byte_t frame_byte;
	int pos;

	assign pos = int'(byte_index);

	// Own addresses are first needed at byte 6
	always_ff @(posedge clk) begin
		if (sending && byte_index == '0) begin
			own_mac <= local_mac[port_index];
			own_ip  <= local_ip[port_index];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Byte mux

	always_comb begin
		frame_byte = '0;
		case (byte_index) inside
			[6'd0:6'd5]: begin
				frame_byte = `ARP_BROADCAST_BYTE;
			end
			[6'd6:6'd11]: begin
				frame_byte = own_mac[8*(11-pos) +: 8];
			end
			[6'd12:6'd21]: begin
				frame_byte = FIXED_HDR[8*(21-pos) +: 8];
			end
			[6'd22:6'd27]: begin
				frame_byte = own_mac[8*(27-pos) +: 8];
			end
			[6'd28:6'd31]: begin
				frame_byte = own_ip[8*(31-pos) +: 8];
			end
			// Target MAC stays zero
			[6'd38:6'd41]: begin
				frame_byte = target_ip[8*(41-pos) +: 8];
			end
			default: begin
				frame_byte = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Output registers

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_data <= '0;
			tx_en   <= '0;
		end else if (sending) begin
			tx_data <= frame_byte;
			tx_en   <= arp_pkg::port_mask_t'(1) << port_index;
		end else begin
			tx_data <= '0;
			tx_en   <= '0;
		end
	end

endmodule

// ==== logic/arp_request_top.sv ====
`timescale 1ns/1ps

module arp_request_top (
	input  logic                      clk,
	input  logic                      rst,
	input  arp_pkg::port_field_t      lut_port,
	input  arp_pkg::ip_addr_t         lut_ip,
	input  logic                      lut_en,
	input  arp_pkg::port_field_t      fade_port,
	input  arp_pkg::ip_addr_t         fade_ip,
	input  logic                      fade_en,
	input  arp_pkg::port_ip_table_t   local_ip,
	input  arp_pkg::port_mac_table_t  local_mac,
	input  arp_pkg::port_mask_t       req_ack,
	output arp_pkg::port_mask_t       req_ready,
	output arp_pkg::tx_byte_t         tx_data,
	output arp_pkg::port_mask_t       tx_en
);

	logic idle;
	logic req_pending;
	logic port_valid;
	logic sending;
	arp_pkg::port_index_t port_index;
	arp_pkg::ip_addr_t target_ip;
	arp_pkg::byte_index_t byte_index;

	arp_request_capture u_capture (
		.clk         (clk),
		.idle        (idle),
		.lut_port    (lut_port),
		.lut_ip      (lut_ip),
		.lut_en      (lut_en),
		.fade_port   (fade_port),
		.fade_ip     (fade_ip),
		.fade_en     (fade_en),
		.req_pending (req_pending),
		.port_valid  (port_valid),
		.port_index  (port_index),
		.target_ip   (target_ip)
	);

	arp_request_sequencer u_sequencer (
		.clk         (clk),
		.rst         (rst),
		.req_pending (req_pending),
		.port_valid  (port_valid),
		.port_index  (port_index),
		.req_ack     (req_ack),
		.idle        (idle),
		.sending     (sending),
		.byte_index  (byte_index),
		.req_ready   (req_ready)
	);

	arp_frame_builder u_builder (
		.clk        (clk),
		.rst        (rst),
		.sending    (sending),
		.byte_index (byte_index),
		.port_index (port_index),
		.target_ip  (target_ip),
		.local_ip   (local_ip),
		.local_mac  (local_mac),
		.tx_data    (tx_data),
		.tx_en      (tx_en)
	);

endmodule

// ==== bench/arp_request_sva.sv ====
`timescale 1ns/1ps
`include "arp_settings.svh"

module arp_request_sva (
	input logic                 clk,
	input logic                 rst,
	input arp_pkg::port_mask_t  req_ready,
	input arp_pkg::port_mask_t  req_ack,
	input arp_pkg::port_mask_t  tx_en
);

	localparam logic [6:0] FRAME_LEN = 7'(`ARP_FRAME_LEN);

	// Consecutive cycles with an enable high
	logic [6:0] run_len;

	always_ff @(posedge clk) begin
		if (rst || tx_en == '0) begin
			run_len <= '0;
		end else begin
			run_len <= run_len + 1'b1;
		end
	end

	a_ready_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(req_ready))
		else $error("req_ready has more than one bit set");

	a_en_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(tx_en))
		else $error("tx_en has more than one bit set");

	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		!((tx_en != '0) && (req_ready != '0)))
		else $error("tx_en high while a ready bit is high");

	// Ready waits for its own ack
	a_ready_held: assert property (@(posedge clk) disable iff (rst)
		(req_ready != '0 && (req_ack & req_ready) == '0) |=> req_ready == $past(req_ready))
		else $error("req_ready changed without a matching ack");

	a_frame_whole: assert property (@(posedge clk) disable iff (rst)
		(run_len != '0 && run_len < FRAME_LEN) |-> tx_en != '0)
		else $error("tx_en fell before the end of the frame");

	a_frame_bounded: assert property (@(posedge clk) disable iff (rst)
		(tx_en != '0) |-> run_len < FRAME_LEN)
		else $error("tx_en stayed high past the frame length");

endmodule

// ==== bench/arp_request_tb.sv ====
`timescale 1ns/1ps
`include "arp_settings.svh"

module arp_request_tb;

	localparam int NUM_REQ = 40;
	localparam int MAX_ACK_DELAY = 12;
	localparam int FRAME_BYTES = 64;
	// Worst case per request plus reset and the idle checks after it
	localparam int CYCLE_LIMIT = NUM_REQ * (FRAME_BYTES + MAX_ACK_DELAY + 8) + 16;

	logic clk;
	logic rst;
	arp_pkg::port_field_t lut_port;
	arp_pkg::ip_addr_t lut_ip;
	logic lut_en;
	arp_pkg::port_field_t fade_port;
	arp_pkg::ip_addr_t fade_ip;
	logic fade_en;
	arp_pkg::port_ip_table_t local_ip;
	arp_pkg::port_mac_table_t local_mac;
	arp_pkg::port_mask_t req_ack;
	arp_pkg::port_mask_t req_ready;
	arp_pkg::tx_byte_t tx_data;
	arp_pkg::port_mask_t tx_en;

	integer seed;
	int error_count;
	int check_count;
	int frame_count;
	int cycle_count;
	arp_pkg::tx_byte_t expected_q[$];

	arp_request_top UUT (
		.clk       (clk),
		.rst       (rst),
		.lut_port  (lut_port),
		.lut_ip    (lut_ip),
		.lut_en    (lut_en),
		.fade_port (fade_port),
		.fade_ip   (fade_ip),
		.fade_en   (fade_en),
		.local_ip  (local_ip),
		.local_mac (local_mac),
		.req_ack   (req_ack),
		.req_ready (req_ready),
		.tx_data   (tx_data),
		.tx_en     (tx_en)
	);

	bind arp_request_top arp_request_sva u_sva (
		.clk       (clk),
		.rst       (rst),
		.req_ready (req_ready),
		.req_ack   (req_ack),
		.tx_en     (tx_en)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
			$display("Checks: %0d, frames: %0d, errors: %0d", check_count, frame_count,
				error_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random helpers

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic int pick_port();
		return int'(rand32() % `ARP_NUM_PORTS);
	endfunction

	// Any port but the given one
	function automatic int pick_other(input int port);
		return (port + 1 + int'(rand32() % (`ARP_NUM_PORTS - 1))) % `ARP_NUM_PORTS;
	endfunction

	function automatic arp_pkg::port_field_t one_hot_field(input int port);
		return arp_pkg::port_field_t'(1) << port;
	endfunction

	task automatic fill_tables();
		logic [63:0] wide;
		for (int p = 0; p < `ARP_NUM_PORTS; p++) begin
			wide = {rand32(), rand32()};
			local_mac[p] = wide[47:0];
			local_ip[p] = rand32();
		end
	endtask

	// Strobes low, junk on the request fields
	task automatic release_inputs();
		logic [31:0] junk;
		lut_en = 1'b0;
		fade_en = 1'b0;
		req_ack = '0;
		junk = rand32();
		lut_port = junk[23:0];
		junk = rand32();
		fade_port = junk[23:0];
		lut_ip = rand32();
		fade_ip = rand32();
	endtask

	task automatic busy_strobe();
		lut_en = 1'b1;
		lut_port = one_hot_field(pick_port());
		lut_ip = rand32();
		fade_en = 1'b1;
		fade_port = one_hot_field(pick_port());
		fade_ip = rand32();
	endtask

	task automatic report_mismatch(input string msg);
		error_count++;
		$display("FAILED at %0t: %s", $time, msg);
	endtask

	task automatic report_problem(input string msg);
		error_count++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic check_quiet(input string where);
		check_count++;
		if (req_ready !== '0 || tx_en !== '0 || tx_data !== '0) begin
			report_mismatch($sformatf("%s: ready %h enable %h data %h, expected all zero",
				where, req_ready, tx_en, tx_data));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Frame model

	task automatic push_bytes(input logic [47:0] value, input int count);
		for (int b = count - 1; b >= 0; b--) begin
			expected_q.push_back(value[8*b +: 8]);
		end
	endtask

	task automatic build_frame(input int port, input arp_pkg::ip_addr_t tgt);
		expected_q.delete();
		push_bytes(48'hffff_ffff_ffff, 6);
		push_bytes(local_mac[port], 6);
		push_bytes(48'h0806, 2);
		push_bytes(48'h0001, 2);
		push_bytes(48'h0800, 2);
		push_bytes(48'h06, 1);
		push_bytes(48'h04, 1);
		push_bytes(48'h0001, 2);
		push_bytes(local_mac[port], 6);
		push_bytes({16'h0, local_ip[port]}, 4);
		// Target MAC unknown
		push_bytes(48'h0, 6);
		push_bytes({16'h0, tgt}, 4);
		while (expected_q.size() < FRAME_BYTES) begin
			expected_q.push_back(8'h00);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Request scenarios

	// Mode 0 lookup, 1 expiry, 2 both, 3 lookup with wrong acks and busy strobes
	task automatic serve_request(input int mode, input int delay);
		int port;
		int wait_cycles;
		arp_pkg::ip_addr_t tgt;
		arp_pkg::port_mask_t port_bit;
		port = pick_port();
		tgt = rand32();
		port_bit = arp_pkg::port_mask_t'(1) << port;
		build_frame(port, tgt);
		if (mode == 1) begin
			fade_en = 1'b1;
			fade_port = one_hot_field(port);
			fade_ip = tgt;
		end else begin
			lut_en = 1'b1;
			lut_port = one_hot_field(port);
			lut_ip = tgt;
		end
		if (mode == 2) begin
			fade_en = 1'b1;
			fade_port = one_hot_field(pick_other(port));
			fade_ip = ~tgt;
		end
		@(negedge clk);
		release_inputs();
		for (int d = 0; d <= delay; d++) begin
			check_count++;
			if (req_ready !== port_bit || tx_en !== '0) begin
				report_mismatch($sformatf("port %0d hold cycle %0d: ready %h enable %h, expected %h",
					port, d, req_ready, tx_en, port_bit));
			end
			if (d < delay && mode == 3) begin
				req_ack = arp_pkg::port_mask_t'(1) << pick_other(port);
			end
			if (d == delay) begin
				req_ack = port_bit;
			end
			if (mode == 3 && (d == 0 || d == delay)) begin
				busy_strobe();
			end
			@(negedge clk);
			release_inputs();
		end
		check_count++;
		if (req_ready !== '0) begin
			report_mismatch($sformatf("port %0d: ready %h still high after the ack", port, req_ready));
		end
		wait_cycles = 0;
		while (tx_en === '0 && wait_cycles < 4) begin
			@(negedge clk);
			release_inputs();
			wait_cycles++;
		end
		if (tx_en === '0) begin
			report_problem($sformatf("frame on port %0d did not start within 4 cycles of its ack",
				port));
			return;
		end
		check_count++;
		if (wait_cycles != 1) begin
			report_mismatch($sformatf("port %0d: frame started %0d cycles late", port, wait_cycles));
		end
		for (int k = 0; k < FRAME_BYTES; k++) begin
			check_count++;
			if (tx_en !== port_bit || tx_data !== expected_q[k] || req_ready !== '0) begin
				report_mismatch($sformatf("port %0d byte %0d: enable %h data %h, expected %h %h",
					port, k, tx_en, tx_data, port_bit, expected_q[k]));
			end
			if (mode == 3 && k == 30) begin
				busy_strobe();
			end
			@(negedge clk);
			release_inputs();
		end
		frame_count++;
		check_quiet("first cycle after frame");
		@(negedge clk);
		release_inputs();
		check_quiet("idle gap");
	endtask

	// Kind 0 zero field, 1 two bits, 2 one bit above the last port
	task automatic invalid_request(input int kind);
		arp_pkg::port_field_t field;
		int a;
		if (kind == 0) begin
			field = '0;
		end else if (kind == 1) begin
			a = pick_port();
			field = one_hot_field(a) | one_hot_field(pick_other(a));
		end else begin
			a = `ARP_NUM_PORTS + int'(rand32() % (`ARP_PORT_FIELD_W - `ARP_NUM_PORTS));
			field = one_hot_field(a);
		end
		lut_en = 1'b1;
		lut_port = field;
		lut_ip = rand32();
		@(negedge clk);
		release_inputs();
		req_ack = '1;
		check_quiet($sformatf("invalid field %h, hold cycle", field));
		@(negedge clk);
		release_inputs();
		check_quiet($sformatf("invalid field %h, back to idle", field));
		// A send started by the ack would show its enable here
		@(negedge clk);
		release_inputs();
		check_quiet($sformatf("invalid field %h, no frame", field));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int mode;
		seed = 79;
		error_count = 0;
		check_count = 0;
		frame_count = 0;
		cycle_count = 0;
		clk = 1'b0;
		rst = 1'b1;
		lut_port = '0;
		lut_ip = '0;
		lut_en = 1'b0;
		fade_port = '0;
		fade_ip = '0;
		fade_en = 1'b0;
		req_ack = '0;
		fill_tables();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		check_quiet("after reset");
		@(negedge clk);
		release_inputs();
		check_quiet("idle after reset");
		for (int i = 0; i < NUM_REQ; i++) begin
			mode = i % 5;
			if (mode == 4) begin
				invalid_request((i / 5) % 3);
			end else if (mode == 3) begin
				serve_request(mode, MAX_ACK_DELAY);
			end else begin
				serve_request(mode, int'(rand32() % (MAX_ACK_DELAY + 1)));
			end
		end
		$display("Checks: %0d, frames: %0d, errors: %0d", check_count, frame_count, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+logic
logic/arp_pkg.sv
logic/arp_request_capture.sv
logic/arp_request_sequencer.sv
logic/arp_frame_builder.sv
logic/arp_request_top.sv
bench/arp_request_sva.sv
bench/arp_request_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ARP request generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
	-f list.f --top-module arp_request_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Varp_request_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	echo "Simulation reported errors, see $LOG"
	exit 1
fi

echo "Simulation finished without errors"
exit 0
